/* gat_attn_core.f */
verilog/gat_pkg.sv
verilog/wh_buf_if.sv
verilog/wh_buffer_arbiter.sv
verilog/spmm_engine.sv
verilog/dmvm_engine.sv
verilog/gat_attn_core.sv
verif/gat_attn_properties.sv
verif/gat_attn_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the GAT attention testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f gat_attn_core.f \
  --top-module gat_attn_tb \
  -Mdir obj_dir -o gat_attn_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/gat_attn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
exit 0

/* verif/gat_attn_cases.txt */
# W col w0 w1 w2 w3 | A a0..a7 | S name nodes | E col val row_end | C coef
# R count adds xorshift subgraphs checked against the model
W 0 1 2 3 4
W 1 -1 0 1 2
W 2 5 -3 0 1
W 3 127 -128 2 -1
A 1 1 1 1 2 -1 0 3
S four_node 4
E 0 1 1
E 1 2 0
E 2 1 1
E 3 1 1
E 0 -3 1
C 22
C 34
C 389
C -26
S one_node 1
E 2 -2 1
C -38
S repeat_neg 2
E 3 -128 0
E 3 -128 0
E 0 127 1
E 1 -1 0
E 2 3 1
C -94230
C 1314
R 20

/* verif/gat_attn_tb.sv */
`default_nettype none

module gat_attn_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  localparam logic [31:0] SEED = 32'h5ce4a768;

  logic              clk;
  logic              rst_n;
  logic              wgt_we_i;
  logic [COL_W-1:0]  wgt_addr_i;
  wgt_row_t          wgt_data_i;
  logic              a_we_i;
  logic [2:0]        a_idx_i;
  logic [DATA_W-1:0] a_data_i;
  logic              sub_start_i;
  logic [CNT_W-1:0]  sub_nodes_i;
  logic              h_vld_i;
  logic [COL_W-1:0]  h_col_i;
  logic [DATA_W-1:0] h_val_i;
  logic              h_row_end_i;
  logic              sub_rdy_o;
  logic              coef_vld_o;
  logic              coef_last_o;
  logic [COEF_W-1:0] coef_o;

  logic [31:0] rng;
  int          wgt_ref [NUM_FEAT_IN][NUM_FEAT_OUT];
  int          a_ref [2*NUM_FEAT_OUT];
  string       case_name [$];
  int          case_nodes [$];
  int          case_first [$];
  int          case_num [$];
  int          case_err [$];
  int          ent_col [$];
  int          ent_val [$];
  int          ent_end [$];
  int          ent_gap [$];
  int          exp_coef [$];
  int          exp_case [$];
  bit          exp_last [$];
  int          got;
  int          err_cnt;
  int          started_coefs;
  bit          overlap_seen;

  gat_attn_core dut_i (.*);

  bind gat_attn_core gat_attn_properties props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sub_start_i (sub_start_i),
    .sub_rdy_o   (sub_rdy_o),
    .coef_vld_o  (coef_vld_o),
    .coef_last_o (coef_last_o),
    .wr_req      (wr_if.req),
    .wr_addr     (wr_if.addr),
    .rd_req      (rd_if.req),
    .rd_addr     (rd_if.addr),
    .rd_gnt      (rd_if.gnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_next();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic void add_case(string name, int nodes);
    case_name.push_back(name);
    case_nodes.push_back(nodes);
    case_first.push_back(ent_col.size());
    case_num.push_back(0);
    case_err.push_back(0);
  endfunction

  function automatic void add_entry(int col, int val, int row_end, int gap);
    ent_col.push_back(col);
    ent_val.push_back(val);
    ent_end.push_back(row_end);
    ent_gap.push_back(gap);
    case_num[case_num.size()-1]++;
  endfunction

  // Builds one random subgraph and its expected coefficients from Wh and a
  task automatic gen_random(input int idx);
    logic [31:0] r;
    int          nodes;
    int          ne;
    int          col;
    int          val;
    int          wh [MAX_NODES][NUM_FEAT_OUT];
    int          tgt;
    int          nbr;
    r = rand_next();
    nodes = int'(r[2:0]) + 1;
    add_case($sformatf("rand_%0d", idx), nodes);
    for (int k = 0; k < nodes; k++) begin
      r = rand_next();
      ne = int'(r[1:0]) + 1;
      for (int f = 0; f < NUM_FEAT_OUT; f++) wh[k][f] = 0;
      for (int e = 0; e < ne; e++) begin
        r = rand_next();
        col = int'(r[3:0]);
        val = int'($signed(r[11:4]));
        for (int f = 0; f < NUM_FEAT_OUT; f++) wh[k][f] += val * wgt_ref[col][f];
        add_entry(col, val, (e == ne - 1) ? 1 : 0, int'(r[13:12]));
      end
    end
    tgt = 0;
    for (int f = 0; f < NUM_FEAT_OUT; f++) tgt += a_ref[f] * wh[0][f];
    for (int k = 0; k < nodes; k++) begin
      nbr = 0;
      for (int f = 0; f < NUM_FEAT_OUT; f++) nbr += a_ref[NUM_FEAT_OUT+f] * wh[k][f];
      exp_coef.push_back(tgt + nbr);
      exp_case.push_back(case_name.size() - 1);
      exp_last.push_back(k == nodes - 1);
    end
  endtask

  task automatic read_cases();
    int                 fd;
    logic [8*160-1:0]   line;
    logic [8*16-1:0]    tag;
    logic [8*16-1:0]    nm;
    int                 v [8];
    int                 n;
    int                 coef_seen;
    fd = $fopen("verif/gat_attn_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file");
      err_cnt++;
    end else begin
      coef_seen = 0;
      while ($fgets(line, fd) > 0) begin
        tag = '0;
        n = $sscanf(line, "%s", tag);
        if (n <= 0 || tag == "#") continue;
        if (tag == "W") begin
          n = $sscanf(line, "%s %d %d %d %d %d", tag, v[0], v[1], v[2], v[3], v[4]);
          for (int f = 0; f < NUM_FEAT_OUT; f++) wgt_ref[v[0]][f] = v[f+1];
        end else if (tag == "A") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d %d", tag,
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
          for (int i = 0; i < 8; i++) a_ref[i] = v[i];
        end else if (tag == "S") begin
          n = $sscanf(line, "%s %s %d", tag, nm, v[0]);
          add_case($sformatf("%0s", nm), v[0]);
          coef_seen = 0;
        end else if (tag == "E") begin
          n = $sscanf(line, "%s %d %d %d", tag, v[0], v[1], v[2]);
          add_entry(v[0], v[1], v[2], 0);
        end else if (tag == "C") begin
          n = $sscanf(line, "%s %d", tag, v[0]);
          coef_seen++;
          exp_coef.push_back(v[0]);
          exp_case.push_back(case_name.size() - 1);
          exp_last.push_back(coef_seen == case_nodes[case_nodes.size()-1]);
        end else if (tag == "R") begin
          n = $sscanf(line, "%s %d", tag, v[0]);
          for (int i = 0; i < v[0]; i++) gen_random(i);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_params();
    for (int c = 0; c < NUM_FEAT_IN; c++) begin
      wgt_we_i   = 1'b1;
      wgt_addr_i = COL_W'(c);
      for (int f = 0; f < NUM_FEAT_OUT; f++) wgt_data_i[f] = DATA_W'(wgt_ref[c][f]);
      @(posedge clk);
      #2;
    end
    wgt_we_i = 1'b0;
    for (int i = 0; i < 2*NUM_FEAT_OUT; i++) begin
      a_we_i   = 1'b1;
      a_idx_i  = 3'(i);
      a_data_i = DATA_W'(a_ref[i]);
      @(posedge clk);
      #2;
    end
    a_we_i = 1'b0;
  endtask

  // Start as soon as sub_rdy_o allows
  task automatic play_case(input int c);
    while (!sub_rdy_o) begin
      @(posedge clk);
      #2;
    end
    if (started_coefs > got) overlap_seen = 1'b1;
    started_coefs += case_nodes[c];
    sub_start_i = 1'b1;
    sub_nodes_i = CNT_W'(case_nodes[c]);
    @(posedge clk);
    #2;
    sub_start_i = 1'b0;
    for (int e = case_first[c]; e < case_first[c] + case_num[c]; e++) begin
      h_vld_i     = 1'b1;
      h_col_i     = COL_W'(ent_col[e]);
      h_val_i     = DATA_W'(ent_val[e]);
      h_row_end_i = (ent_end[e] != 0);
      @(posedge clk);
      #2;
      h_vld_i     = 1'b0;
      h_row_end_i = 1'b0;
      repeat (ent_gap[e]) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  always @(negedge clk) begin
    int c;
    if (rst_n && coef_vld_o) begin
      if (got >= exp_coef.size()) begin
        $display("coefficient arrived with no test pending");
        err_cnt++;
      end else begin
        c = exp_case[got];
        if ($signed(coef_o) != exp_coef[got]) begin
          $display("[ERROR] %0s coef expected %0d actual %0d",
                   case_name[c], exp_coef[got], $signed(coef_o));
          err_cnt++;
          case_err[c]++;
        end
        if (coef_last_o != exp_last[got]) begin
          $display("[ERROR] %0s coef_last expected %0d actual %0d",
                   case_name[c], exp_last[got], coef_last_o);
          err_cnt++;
          case_err[c]++;
        end
        if (exp_last[got]) begin
          $display("test %0s %s", case_name[c], (case_err[c] == 0) ? "ok" : "FAILED");
        end
      end
      got++;
    end
  end

  initial begin
    int limit;
    int passed;
    input_init: begin
      rst_n       = 1'b0;
      wgt_we_i    = 1'b0;
      wgt_addr_i  = '0;
      wgt_data_i  = '0;
      a_we_i      = 1'b0;
      a_idx_i     = '0;
      a_data_i    = '0;
      sub_start_i = 1'b0;
      sub_nodes_i = '0;
      h_vld_i     = 1'b0;
      h_col_i     = '0;
      h_val_i     = '0;
      h_row_end_i = 1'b0;
    end
    got           = 0;
    err_cnt       = 0;
    started_coefs = 0;
    overlap_seen  = 1'b0;
    rng           = SEED;
    // Case file rows overwrite these random weights
    for (int c = 0; c < NUM_FEAT_IN; c++) begin
      for (int f = 0; f < NUM_FEAT_OUT; f++) wgt_ref[c][f] = int'($signed(rand_next()) % 128);
    end
    read_cases();
    limit = 200 * (ent_col.size() + exp_coef.size());
    fork
      begin
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles", limit);
        $display("Regression failed");
        $finish;
      end
    join_none
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    if (sub_rdy_o !== 1'b1 || coef_vld_o !== 1'b0 || coef_last_o !== 1'b0) begin
      $display("outputs not in their reset state after reset");
      err_cnt++;
    end
    load_params();
    for (int c = 0; c < case_name.size(); c++) play_case(c);
    wait (got >= exp_coef.size());
    repeat (10) @(posedge clk);
    if (!overlap_seen) begin
      $display("no two subgraphs were in flight at once");
      err_cnt++;
    end
    passed = 0;
    foreach (case_err[i]) if (case_err[i] == 0) passed++;
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             case_name.size(), passed, case_name.size() - passed, err_cnt);
    if (err_cnt == 0 && got == exp_coef.size()) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/gat_attn_properties.sv */
`default_nettype none

module gat_attn_properties (
  input wire logic                          clk,
  input wire logic                          rst_n,
  input wire logic                          sub_start_i,
  input wire logic                          sub_rdy_o,
  input wire logic                          coef_vld_o,
  input wire logic                          coef_last_o,
  input wire logic                          wr_req,
  input wire logic [gat_pkg::WH_ADDR_W-1:0] wr_addr,
  input wire logic                          rd_req,
  input wire logic [gat_pkg::WH_ADDR_W-1:0] rd_addr,
  input wire logic                          rd_gnt
);
  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  // Reader waits on the port with a steady request
  assert property (@(posedge clk) disable iff (!rst_n)
    rd_req && !rd_gnt |=> rd_req && $stable(rd_addr))
    else $error("read request dropped or moved before its grant");

  // SPMM never writes the bank under read
  assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && rd_req |-> wr_addr[WH_ADDR_W-1] != rd_addr[WH_ADDR_W-1])
    else $error("write hit the bank that DMVM is reading");

  assert property (@(posedge clk) disable iff (!rst_n) coef_last_o |-> coef_vld_o)
    else $error("coef_last_o without coef_vld_o");

  assert property (@(posedge clk) disable iff (!rst_n) sub_start_i |-> sub_rdy_o)
    else $error("subgraph started while sub_rdy_o low");

endmodule

`default_nettype wire

/* verilog/gat_attn_core.sv */
`default_nettype none

module gat_attn_core #(
  parameter int NUM_FEAT_OUT = gat_pkg::NUM_FEAT_OUT,
  parameter int MAX_NODES    = gat_pkg::MAX_NODES
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wgt_we_i,
  input  logic [gat_pkg::COL_W-1:0]  wgt_addr_i,
  input  gat_pkg::wgt_row_t          wgt_data_i,
  input  logic                       a_we_i,
  input  logic [2:0]                 a_idx_i,
  input  logic [gat_pkg::DATA_W-1:0] a_data_i,
  input  logic                       sub_start_i,
  input  logic [gat_pkg::CNT_W-1:0]  sub_nodes_i,
  input  logic                       h_vld_i,
  input  logic [gat_pkg::COL_W-1:0]  h_col_i,
  input  logic [gat_pkg::DATA_W-1:0] h_val_i,
  input  logic                       h_row_end_i,
  output logic                       sub_rdy_o,
  output logic                       coef_vld_o,
  output logic                       coef_last_o,
  output logic [gat_pkg::COEF_W-1:0] coef_o
);
  import gat_pkg::*;

  logic             bank_done;
  logic             done_bank;
  logic [CNT_W-1:0] done_cnt;
  logic             bank_free;

  wh_buf_if wr_if ();
  wh_buf_if rd_if ();

  spmm_engine #(
    .NUM_FEAT_OUT (NUM_FEAT_OUT),
    .MAX_NODES    (MAX_NODES)
  ) u_spmm (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_we_i    (wgt_we_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .sub_start_i (sub_start_i),
    .sub_nodes_i (sub_nodes_i),
    .h_vld_i     (h_vld_i),
    .h_col_i     (h_col_i),
    .h_val_i     (h_val_i),
    .h_row_end_i (h_row_end_i),
    .bank_free_i (bank_free),
    .sub_rdy_o   (sub_rdy_o),
    .bank_done_o (bank_done),
    .done_bank_o (done_bank),
    .done_cnt_o  (done_cnt),
    .wr_if       (wr_if.requester)
  );

  dmvm_engine #(
    .NUM_FEAT_OUT (NUM_FEAT_OUT)
  ) u_dmvm (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_we_i      (a_we_i),
    .a_idx_i     (a_idx_i),
    .a_data_i    (a_data_i),
    .bank_done_i (bank_done),
    .done_bank_i (done_bank),
    .done_cnt_i  (done_cnt),
    .bank_free_o (bank_free),
    .coef_vld_o  (coef_vld_o),
    .coef_last_o (coef_last_o),
    .coef_o      (coef_o),
    .rd_if       (rd_if.requester)
  );

  wh_buffer_arbiter #(
    .MAX_NODES (MAX_NODES)
  ) u_wh_arb (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_if (wr_if.arbiter),
    .rd_if (rd_if.arbiter)
  );

endmodule

`default_nettype wire

/* verilog/dmvm_engine.sv */
`default_nettype none

module dmvm_engine #(
  parameter int NUM_FEAT_OUT = gat_pkg::NUM_FEAT_OUT
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       a_we_i,
  input  logic [2:0]                 a_idx_i,
  input  logic [gat_pkg::DATA_W-1:0] a_data_i,
  input  logic                       bank_done_i,
  input  logic                       done_bank_i,
  input  logic [gat_pkg::CNT_W-1:0]  done_cnt_i,
  output logic                       bank_free_o,
  output logic                       coef_vld_o,
  output logic                       coef_last_o,
  output logic [gat_pkg::COEF_W-1:0] coef_o,
  wh_buf_if.requester                rd_if
);
  import gat_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_TGT, S_TGW, S_NBR} state_t;

  state_t                   state;
  data_t                    a_q [2*NUM_FEAT_OUT];
  logic [1:0]               pend;
  logic [CNT_W-1:0]         cnt_q [2];
  logic                     cur_bank;
  logic [NODE_W-1:0]        rd_idx;
  logic                     rd_pend;
  logic                     rd_last;
  logic                     last_rd;
  logic signed [COEF_W-1:0] tgt_q;
  logic signed [COEF_W-1:0] tgt_dot;
  logic signed [COEF_W-1:0] nbr_dot;

  always_comb begin
    tgt_dot = '0;
    nbr_dot = '0;
    for (int f = 0; f < NUM_FEAT_OUT; f++) begin
      tgt_dot = tgt_dot + a_q[f] * rd_if.rdata[f];
      nbr_dot = nbr_dot + a_q[NUM_FEAT_OUT+f] * rd_if.rdata[f];
    end
  end

  // Node 0 is read first for the target term, rd_idx stays 0 until then
  assign rd_if.req   = (state == S_TGT) || (state == S_NBR);
  assign rd_if.we    = 1'b0;
  assign rd_if.addr  = {cur_bank, rd_idx};
  assign rd_if.wdata = '0;

  assign last_rd = CNT_W'(rd_idx) + 1'b1 == cnt_q[cur_bank];

  always_ff @(posedge clk) begin
    if (a_we_i) begin
      a_q[a_idx_i] <= a_data_i;
    end
    if (bank_done_i) begin
      cnt_q[done_bank_i] <= done_cnt_i;
    end
    if (state == S_TGW) begin
      tgt_q <= tgt_dot;
    end
    if (rd_pend) begin
      coef_o <= tgt_q + nbr_dot;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= S_IDLE;
      pend        <= '0;
      cur_bank    <= 1'b0;
      rd_idx      <= '0;
      rd_pend     <= 1'b0;
      rd_last     <= 1'b0;
      bank_free_o <= 1'b0;
      coef_vld_o  <= 1'b0;
      coef_last_o <= 1'b0;
    end else begin
      bank_free_o <= 1'b0;
      rd_pend     <= 1'b0;
      coef_vld_o  <= rd_pend;
      coef_last_o <= rd_pend & rd_last;
      if (bank_done_i) begin
        pend[done_bank_i] <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (pend[cur_bank]) begin
            rd_idx <= '0;
            state  <= S_TGT;
          end
        end
        S_TGT: begin
          if (rd_if.gnt) begin
            state <= S_TGW;
          end
        end
        S_TGW: state <= S_NBR;
        S_NBR: begin
          if (rd_if.gnt) begin
            rd_pend <= 1'b1;
            rd_last <= last_rd;
            rd_idx  <= rd_idx + 1'b1;
            // Last row is latched in the buffer, bank can be refilled
            if (last_rd) begin
              pend[cur_bank] <= 1'b0;
              cur_bank       <= ~cur_bank;
              bank_free_o    <= 1'b1;
              state          <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/spmm_engine.sv */
`default_nettype none

module spmm_engine #(
  parameter int NUM_FEAT_OUT = gat_pkg::NUM_FEAT_OUT,
  parameter int MAX_NODES    = gat_pkg::MAX_NODES
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wgt_we_i,
  input  logic [gat_pkg::COL_W-1:0]  wgt_addr_i,
  input  gat_pkg::wgt_row_t          wgt_data_i,
  input  logic                       sub_start_i,
  input  logic [gat_pkg::CNT_W-1:0]  sub_nodes_i,
  input  logic                       h_vld_i,
  input  logic [gat_pkg::COL_W-1:0]  h_col_i,
  input  logic [gat_pkg::DATA_W-1:0] h_val_i,
  input  logic                       h_row_end_i,
  input  logic                       bank_free_i,
  output logic                       sub_rdy_o,
  output logic                       bank_done_o,
  output logic                       done_bank_o,
  output logic [gat_pkg::CNT_W-1:0]  done_cnt_o,
  wh_buf_if.requester                wr_if
);
  import gat_pkg::*;

  localparam int IDX_W = $clog2(MAX_NODES);

  wgt_row_t           wgt_mem [NUM_FEAT_IN];
  logic               s1_vld;
  logic               s1_end;
  logic [COL_W-1:0]   s1_col;
  data_t              s1_val;
  logic               s2_vld;
  logic               s2_end;
  data_t              s2_val;
  wgt_row_t           s2_wgt;
  wh_row_t            acc;
  wh_row_t            acc_nxt;
  logic               filling;
  logic               fill_bank;
  logic               free_ptr;
  logic [1:0]         busy;
  logic [CNT_W-1:0]   sub_cnt;
  logic [IDX_W-1:0]   node_idx;
  logic               row_wr;
  logic               last_wr;

  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_mem[wgt_addr_i] <= wgt_data_i;
    end
    s1_col <= h_col_i;
    s1_val <= h_val_i;
    s1_end <= h_row_end_i;
    // Weight row fetch
    s2_wgt <= wgt_mem[s1_col];
    s2_val <= s1_val;
    s2_end <= s1_end;
  end

  always_comb begin
    for (int f = 0; f < NUM_FEAT_OUT; f++) begin
      acc_nxt[f] = acc[f] + s2_val * s2_wgt[f];
    end
  end

  assign row_wr  = s2_vld & s2_end;
  assign last_wr = row_wr && (CNT_W'(node_idx) + 1'b1 == sub_cnt);

  // Row end writes the finished sum, bypassing the accumulator
  assign wr_if.req   = row_wr;
  assign wr_if.we    = row_wr;
  assign wr_if.addr  = {fill_bank, node_idx};
  assign wr_if.wdata = acc_nxt;

  assign sub_rdy_o = ~filling & ~busy[fill_bank];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld      <= 1'b0;
      s2_vld      <= 1'b0;
      acc         <= '0;
      filling     <= 1'b0;
      fill_bank   <= 1'b0;
      free_ptr    <= 1'b0;
      busy        <= '0;
      sub_cnt     <= '0;
      node_idx    <= '0;
      bank_done_o <= 1'b0;
      done_bank_o <= 1'b0;
      done_cnt_o  <= '0;
    end else begin
      s1_vld      <= h_vld_i;
      s2_vld      <= s1_vld;
      bank_done_o <= last_wr;
      if (s2_vld) begin
        acc <= s2_end ? '0 : acc_nxt;
      end
      if (sub_start_i && sub_rdy_o) begin
        filling         <= 1'b1;
        sub_cnt         <= sub_nodes_i;
        node_idx        <= '0;
        busy[fill_bank] <= 1'b1;
      end
      if (row_wr) begin
        node_idx <= node_idx + 1'b1;
      end
      if (last_wr) begin
        filling     <= 1'b0;
        fill_bank   <= ~fill_bank;
        done_bank_o <= fill_bank;
        done_cnt_o  <= sub_cnt;
      end
      // Banks are released in fill order
      if (bank_free_i) begin
        busy[free_ptr] <= 1'b0;
        free_ptr       <= ~free_ptr;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/wh_buffer_arbiter.sv */
`default_nettype none

module wh_buffer_arbiter #(
  parameter int MAX_NODES = gat_pkg::MAX_NODES
) (
  input  logic       clk,
  input  logic       rst_n,
  wh_buf_if.arbiter  wr_if,
  wh_buf_if.arbiter  rd_if
);
  import gat_pkg::*;

  wh_row_t              mem [2*MAX_NODES];
  wh_row_t              rdata_q;
  logic                 access;
  logic                 sel_we;
  logic [WH_ADDR_W-1:0] sel_addr;
  wh_row_t              sel_wdata;

  // Writer always wins
  assign wr_if.gnt = wr_if.req;
  assign rd_if.gnt = rd_if.req & ~wr_if.req;

  assign access    = wr_if.req | rd_if.req;
  assign sel_we    = wr_if.req ? wr_if.we    : rd_if.we;
  assign sel_addr  = wr_if.req ? wr_if.addr  : rd_if.addr;
  assign sel_wdata = wr_if.req ? wr_if.wdata : rd_if.wdata;

  always_ff @(posedge clk) begin
    if (access && sel_we) begin
      mem[sel_addr] <= sel_wdata;
    end
  end

  // Read data one cycle after grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (access && !sel_we) begin
      rdata_q <= mem[sel_addr];
    end
  end

  assign wr_if.rdata = rdata_q;
  assign rd_if.rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/wh_buf_if.sv */
`default_nettype none

interface wh_buf_if;
  import gat_pkg::*;

  logic                 req;
  logic                 we;
  logic [WH_ADDR_W-1:0] addr;
  wh_row_t              wdata;
  logic                 gnt;
  wh_row_t              rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

`default_nettype wire

/* verilog/gat_pkg.sv */
`default_nettype none

package gat_pkg;

  // Feature and weight values
  localparam int DATA_W       = 8;
  localparam int NUM_FEAT_IN  = 16;
  localparam int COL_W        = 4;
  localparam int NUM_FEAT_OUT = 4;

  // Subgraph size, target node included
  localparam int MAX_NODES    = 8;
  localparam int NODE_W       = 3;
  localparam int CNT_W        = 4;

  // 16 products of 8x8 bits
  localparam int WH_DATA_W    = 20;
  // 8 products of 8x20 bits
  localparam int COEF_W       = 32;

  // Bank bit above the node index
  localparam int WH_ADDR_W    = 4;

  typedef logic signed [DATA_W-1:0]    data_t;
  typedef logic signed [WH_DATA_W-1:0] wh_data_t;

  typedef wh_data_t [NUM_FEAT_OUT-1:0] wh_row_t;
  typedef data_t    [NUM_FEAT_OUT-1:0] wgt_row_t;

endpackage

`default_nettype wire
